// File: hdl/bridgeCtrl.sv
// Bridge controller
// Pops bytes into the packer lane by lane, presents the word on the
// stream and generates clear-to-send from the FIFO fill

`timescale 1ns/10ps
`default_nettype none

module bridgeCtrl
    import serialPkg::*;
    import streamPkg::*;
(
    input  logic                        aclk,
    input  logic                        resetn,
    input  logic                        i_fifoEmpty,
    input  logic [FILL_WIDTH-1:0]       i_fifoFill,
    input  logic                        i_tready,
    output logic                        o_fifoPop,
    output logic                        o_laneLoad,
    output logic [LANE_INDEX_WIDTH-1:0] o_laneIndex,
    output logic                        o_tvalid,
    output logic                        o_cts
);
    ctrlState_e                  state;
    logic [LANE_INDEX_WIDTH-1:0] laneCount;
    logic                        lastLane;

    // One byte per cycle while collecting and data is waiting
    assign o_fifoPop   = (state == ST_COLLECT) && !i_fifoEmpty;
    assign o_laneLoad  = o_fifoPop;
    assign o_laneIndex = laneCount;
    assign o_tvalid    = (state == ST_PRESENT);
    assign lastLane    = (laneCount == LANE_INDEX_WIDTH'(LANES - 1));

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state     <= ST_COLLECT;
            laneCount <= '0;
        end
        else
        begin
            case (state)
                ST_COLLECT:
                begin
                    if (o_fifoPop)
                    begin
                        laneCount <= laneCount + 1'b1;
                        if (lastLane)
                        begin
                            state <= ST_PRESENT;
                        end
                    end
                end
                ST_PRESENT:
                begin
                    // Hold word and valid until the sink takes it
                    if (i_tready)
                    begin
                        state <= ST_COLLECT;
                    end
                end
                default:
                begin
                    state <= ST_COLLECT;
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            o_cts <= 1'b1;
        end
        else
        begin
            o_cts <= (i_fifoFill < FILL_WIDTH'(CTS_THRESHOLD));
        end
    end

endmodule

`default_nettype wire

// File: hdl/byteFifo.sv
// Byte FIFO
// Synchronous circular buffer, head entry always on the read port,
// with an occupancy count for flow control

`timescale 1ns/10ps
`default_nettype none

module byteFifo
    import serialPkg::*;
(
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  i_write,
    input  logic [BYTE_WIDTH-1:0] i_writeData,
    input  logic                  i_pop,
    output logic [BYTE_WIDTH-1:0] o_readData,
    output logic                  o_empty,
    output logic [FILL_WIDTH-1:0] o_fill
);
    logic [BYTE_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [FILL_WIDTH-2:0] wrPtr;
    logic [FILL_WIDTH-2:0] rdPtr;
    logic [FILL_WIDTH-1:0] fill;
    logic                  full;
    logic                  doWrite;
    logic                  doPop;

    assign full    = (fill == FILL_WIDTH'(FIFO_DEPTH));
    assign o_empty = (fill == '0);

    // Writes into a full buffer are lost
    assign doWrite = i_write && !full;
    assign doPop   = i_pop && !o_empty;

    always_ff @(posedge aclk)
    begin
        if (doWrite)
        begin
            mem[wrPtr] <= i_writeData;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end
        else
        begin
            if (doWrite)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doPop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign o_readData = mem[rdPtr];
    assign o_fill     = fill;

endmodule

`default_nettype wire

// File: hdl/serialPkg.sv
// Serial side definitions
// Byte width, receive FIFO sizing and the clear-to-send threshold

`default_nettype none

package serialPkg;

    // One SPI transfer unit
    localparam int BYTE_WIDTH = 8;

    // Receive buffer, must stay a power of two so the pointers wrap freely
    localparam int FIFO_DEPTH = 64;

    // Enough bits to count from empty up to completely full
    localparam int FILL_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Host may keep sending while fewer bytes than this are buffered
    localparam int CTS_THRESHOLD = 16;

endpackage

`default_nettype wire

// File: hdl/serialToStream.sv
// Serial to stream bridge
// SPI bytes are buffered, packed four to a word, LSB first, and sent
// out on a valid/ready stream with clear-to-send pacing for the host

`timescale 1ns/10ps
`default_nettype none

module serialToStream
    import serialPkg::*;
    import streamPkg::*;
(
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  i_sck,
    input  logic                  i_mosi,
    input  logic                  i_ncs,
    output logic                  o_miso,
    output logic                  o_cts,
    output logic                  o_tvalid,
    input  logic                  i_tready,
    output logic [WORD_WIDTH-1:0] o_tdata
);
    logic                        byteValid;
    logic [BYTE_WIDTH-1:0]       rxByte;
    logic [BYTE_WIDTH-1:0]       fifoData;
    logic                        fifoEmpty;
    logic [FILL_WIDTH-1:0]       fifoFill;
    logic                        fifoPop;
    logic                        laneLoad;
    logic [LANE_INDEX_WIDTH-1:0] laneIndex;

    spiRx spiRx_i (
        .aclk        (aclk),
        .resetn      (resetn),
        .i_sck       (i_sck),
        .i_mosi      (i_mosi),
        .i_ncs       (i_ncs),
        .o_miso      (o_miso),
        .o_byteValid (byteValid),
        .o_rxByte    (rxByte)
    );

    byteFifo byteFifo_i (
        .aclk        (aclk),
        .resetn      (resetn),
        .i_write     (byteValid),
        .i_writeData (rxByte),
        .i_pop       (fifoPop),
        .o_readData  (fifoData),
        .o_empty     (fifoEmpty),
        .o_fill      (fifoFill)
    );

    wordPacker wordPacker_i (
        .aclk        (aclk),
        .i_laneLoad  (laneLoad),
        .i_laneIndex (laneIndex),
        .i_byte      (fifoData),
        .o_word      (o_tdata)
    );

    bridgeCtrl bridgeCtrl_i (
        .aclk        (aclk),
        .resetn      (resetn),
        .i_fifoEmpty (fifoEmpty),
        .i_fifoFill  (fifoFill),
        .i_tready    (i_tready),
        .o_fifoPop   (fifoPop),
        .o_laneLoad  (laneLoad),
        .o_laneIndex (laneIndex),
        .o_tvalid    (o_tvalid),
        .o_cts       (o_cts)
    );

endmodule

`default_nettype wire

// File: hdl/spiRx.sv
// SPI mode 0 receiver
// Oversamples SCK in the aclk domain, assembles bytes MSB first and
// echoes the previously received byte back on MISO

`timescale 1ns/10ps
`default_nettype none

module spiRx
    import serialPkg::*;
(
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  i_sck,
    input  logic                  i_mosi,
    input  logic                  i_ncs,
    output logic                  o_miso,
    output logic                  o_byteValid,
    output logic [BYTE_WIDTH-1:0] o_rxByte
);
    // Synchronizer chains, bit 1 is the usable output
    logic [1:0]                    sckSync;
    logic [1:0]                    mosiSync;
    logic [1:0]                    ncsSync;
    logic                          sckLast;
    logic                          selected;
    logic                          sckRise;
    logic                          sckFall;
    logic [$clog2(BYTE_WIDTH)-1:0] bitCount;
    logic [BYTE_WIDTH-1:0]         shiftReg;
    logic [BYTE_WIDTH-1:0]         nextByte;
    logic [BYTE_WIDTH-1:0]         lastByte;
    logic [BYTE_WIDTH-1:0]         echo;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            sckSync  <= '0;
            mosiSync <= '0;
            ncsSync  <= '1;
            sckLast  <= 1'b0;
        end
        else
        begin
            sckSync  <= {sckSync[0], i_sck};
            mosiSync <= {mosiSync[0], i_mosi};
            ncsSync  <= {ncsSync[0], i_ncs};
            sckLast  <= sckSync[1];
        end
    end

    assign selected = !ncsSync[1];
    assign sckRise  = selected && sckSync[1] && !sckLast;
    assign sckFall  = selected && !sckSync[1] && sckLast;
    assign nextByte = {shiftReg[BYTE_WIDTH-2:0], mosiSync[1]};

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            bitCount    <= '0;
            o_byteValid <= 1'b0;
            lastByte    <= '0;
            echo        <= '0;
        end
        else
        begin
            o_byteValid <= 1'b0;
            if (!selected)
            begin
                // Deselect drops any partial byte and rearms the echo
                bitCount <= '0;
                echo     <= lastByte;
            end
            else if (sckRise)
            begin
                bitCount <= bitCount + 1'b1;
                if (&bitCount)
                begin
                    o_byteValid <= 1'b1;
                    lastByte    <= nextByte;
                    echo        <= nextByte;
                end
            end
            else if (sckFall && bitCount != '0)
            begin
                // No shift on the falling edge that closes a byte
                echo <= {echo[BYTE_WIDTH-2:0], 1'b0};
            end
        end
    end

    // Data path only, the bit counter qualifies it
    always_ff @(posedge aclk)
    begin
        if (sckRise)
        begin
            shiftReg <= nextByte;
        end
    end

    assign o_rxByte = shiftReg;
    assign o_miso   = echo[BYTE_WIDTH-1];

endmodule

`default_nettype wire

// File: hdl/streamPkg.sv
// Stream side definitions
// Output word geometry and the controller state encoding

`default_nettype none

package streamPkg;

    localparam int WORD_WIDTH = 32;

    // Bytes per stream word, lane 0 is the least significant byte
    localparam int LANES = 4;
    localparam int LANE_INDEX_WIDTH = $clog2(LANES);

    // Collect bytes from the FIFO, then present the finished word
    typedef enum logic {
        ST_COLLECT,
        ST_PRESENT
    } ctrlState_e;

endpackage

`default_nettype wire

// File: hdl/wordPacker.sv
// Word packer
// Drops each popped byte into its lane of the outgoing stream word

`timescale 1ns/10ps
`default_nettype none

module wordPacker
    import serialPkg::*;
    import streamPkg::*;
(
    input  logic                        aclk,
    input  logic                        i_laneLoad,
    input  logic [LANE_INDEX_WIDTH-1:0] i_laneIndex,
    input  logic [BYTE_WIDTH-1:0]       i_byte,
    output logic [WORD_WIDTH-1:0]       o_word
);
    logic [WORD_WIDTH-1:0] word;

    // Only loads change the word, so it stays put while presented
    always_ff @(posedge aclk)
    begin
        if (i_laneLoad)
        begin
            word[i_laneIndex * BYTE_WIDTH +: BYTE_WIDTH] <= i_byte;
        end
    end

    assign o_word = word;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the serial to stream bridge simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module serialToStreamTb -f vlog.f -o simv \
    && ./obj_dir/simv \
    || exit 1

// File: sim/serialToStreamTb.sv
// Serial to stream bridge testbench
// Table-driven SPI host and a random-ready stream sink, checking word
// order and content, held data under stall, MISO echo and clear-to-send

`timescale 1ns/10ps
`default_nettype none

module serialToStreamTb
    import serialPkg::*;
    import streamPkg::*;
();
    localparam int          SCK_HALF        = 5;
    localparam int          NUM_ROWS        = 8;
    localparam int          MAX_STALL_WORDS = 8;
    localparam int          RESET_TIMEOUT   = 100;
    localparam int          CTS_TIMEOUT     = 1000;
    localparam int          DRAIN_TIMEOUT   = 4000;
    localparam logic [31:0] LFSR_SEED       = 32'he4428019;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] sendOrder;
        logic [WORD_WIDTH-1:0] expWord;
        logic                  abortFirst;
        logic                  stallAfter;
    } stimRow_t;

    // Bytes in send order (first byte leftmost), expected word, abort, stall
    localparam stimRow_t STIM_TABLE [NUM_ROWS] = '{
        '{32'h11223344, 32'h44332211, 1'b0, 1'b0},
        '{32'hA55A0FF0, 32'hF00F5AA5, 1'b0, 1'b0},
        '{32'h00FF00FF, 32'hFF00FF00, 1'b0, 1'b0},
        '{32'hDEADBEEF, 32'hEFBEADDE, 1'b1, 1'b0},
        '{32'h01020408, 32'h08040201, 1'b0, 1'b0},
        '{32'hC33C9669, 32'h69963CC3, 1'b0, 1'b1},
        '{32'h807F01FE, 32'hFE017F80, 1'b0, 1'b0},
        '{32'h5EE51221, 32'h2112E55E, 1'b1, 1'b0}
    };

    logic                  aclk;
    logic                  resetn;
    logic                  sck;
    logic                  mosi;
    logic                  ncs;
    logic                  miso;
    logic                  cts;
    logic                  tvalid;
    logic                  tready;
    logic [WORD_WIDTH-1:0] tdata;
    logic [WORD_WIDTH-1:0] expected [$];
    logic [31:0]           hostLfsr;
    logic [31:0]           sinkLfsr;
    logic [BYTE_WIDTH-1:0] prevByte;
    logic                  stallActive;
    int                    bytesSent;
    int                    wordsReceived;

    tbClock clock_i (
        .aclk   (aclk),
        .resetn (resetn)
    );

    serialToStream dut_i (
        .aclk     (aclk),
        .resetn   (resetn),
        .i_sck    (sck),
        .i_mosi   (mosi),
        .i_ncs    (ncs),
        .o_miso   (miso),
        .o_cts    (cts),
        .o_tvalid (tvalid),
        .i_tready (tready),
        .o_tdata  (tdata)
    );

    // Fibonacci LFSR with taps 32 22 2 1 and the new bit entering at bit 0
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [BYTE_WIDTH-1:0] wireByte(input logic [WORD_WIDTH-1:0] sendOrder,
                                                       input int k);
        return sendOrder[WORD_WIDTH-1-BYTE_WIDTH*k -: BYTE_WIDTH];
    endfunction

    // First byte on the wire lands in lane 0
    function automatic logic [WORD_WIDTH-1:0] packLsbFirst(input logic [WORD_WIDTH-1:0] sendOrder);
        logic [WORD_WIDTH-1:0] word;
        for (int k = 0; k < LANES; k++)
        begin
            word[BYTE_WIDTH*k +: BYTE_WIDTH] = wireByte(sendOrder, k);
        end
        return word;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Mode 0 bits MSB first where each rising edge also samples the echo
    task automatic shiftBits(input logic [BYTE_WIDTH-1:0] value, input int count);
        for (int k = 0; k < count; k++)
        begin
            @(posedge aclk);
            mosi <= value[BYTE_WIDTH-1-k];
            repeat (SCK_HALF - 1) @(posedge aclk);
            sck <= 1'b1;
            assert (miso == prevByte[BYTE_WIDTH-1-k])
            else failRun($sformatf("error at %0d ns: o_miso bit %0d is %b, expected %b",
                                   $time, k, miso, prevByte[BYTE_WIDTH-1-k]));
            repeat (SCK_HALF) @(posedge aclk);
            sck <= 1'b0;
        end
        repeat (SCK_HALF) @(posedge aclk);
    endtask

    task automatic sendByte(input logic [BYTE_WIDTH-1:0] value);
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++)
        begin
            hostLfsr = lfsrStep(hostLfsr);
            gap = gap * 2 + int'(hostLfsr[0]);
        end
        repeat (gap) @(posedge aclk);
        shiftBits(value, BYTE_WIDTH);
        prevByte = value;
        bytesSent++;
    endtask

    // Three bits then deselect so the partial byte must vanish
    task automatic abortPartialByte();
        shiftBits(8'hE0, 3);
        ncs <= 1'b1;
        repeat (2 * SCK_HALF) @(posedge aclk);
        ncs <= 1'b0;
        repeat (SCK_HALF) @(posedge aclk);
    endtask

    // Ready held low while random words pile up in the FIFO
    task automatic stallPhase();
        logic [WORD_WIDTH-1:0] sendOrder;
        int                    fill;
        int                    words;
        int                    cycles;
        fill = 0;
        words = 0;
        sendOrder = '0;
        @(negedge aclk);
        stallActive = 1'b1;
        while (fill <= CTS_THRESHOLD && words < MAX_STALL_WORDS)
        begin
            for (int b = 0; b < WORD_WIDTH; b++)
            begin
                hostLfsr = lfsrStep(hostLfsr);
                sendOrder = {sendOrder[WORD_WIDTH-2:0], hostLfsr[0]};
            end
            expected.push_back(packLsbFirst(sendOrder));
            for (int k = 0; k < LANES; k++)
            begin
                sendByte(wireByte(sendOrder, k));
                @(negedge aclk);
                if (tvalid)
                begin
                    // Presented word bytes are already out of the FIFO
                    fill = bytesSent - LANES * (wordsReceived + 1);
                    assert (cts == (fill < CTS_THRESHOLD))
                    else failRun($sformatf("error at %0d ns: o_cts is %b, expected %b at fill %0d",
                                           $time, cts, fill < CTS_THRESHOLD, fill));
                end
            end
            words++;
        end
        assert (fill > CTS_THRESHOLD)
        else failRun("FIFO fill never passed the clear-to-send threshold while stalled");
        @(negedge aclk);
        stallActive = 1'b0;
        cycles = 0;
        while (!cts && cycles < CTS_TIMEOUT)
        begin
            @(posedge aclk);
            cycles++;
        end
        assert (cts) else failRun("timeout waiting for o_cts to rise after the stall");
    endtask

    // Stream sink with random ready plus in-order and hold checks
    initial
    begin : streamSink
        logic [WORD_WIDTH-1:0] heldWord;
        logic [WORD_WIDTH-1:0] want;
        logic                  holding;
        holding = 1'b0;
        heldWord = '0;
        forever
        begin
            @(posedge aclk);
            if (resetn)
            begin
                if (holding)
                begin
                    assert (tvalid)
                    else failRun($sformatf("error at %0d ns: o_tvalid is %b, expected %b",
                                           $time, tvalid, 1'b1));
                    assert (tdata == heldWord)
                    else failRun($sformatf("error at %0d ns: o_tdata is %h, expected %h",
                                           $time, tdata, heldWord));
                end
                if (tvalid && tready)
                begin
                    assert (expected.size() > 0)
                    else failRun("stream delivered a word that was never sent");
                    want = expected.pop_front();
                    assert (tdata == want)
                    else failRun($sformatf("error at %0d ns: o_tdata is %h, expected %h",
                                           $time, tdata, want));
                    wordsReceived++;
                end
                holding = tvalid && !tready;
                heldWord = tdata;
                sinkLfsr = lfsrStep(sinkLfsr);
                tready <= stallActive ? 1'b0 : sinkLfsr[0];
            end
        end
    end

    initial
    begin : hostSequence
        int cycles;
        sck = 1'b0;
        mosi = 1'b0;
        ncs = 1'b1;
        tready = 1'b0;
        hostLfsr = LFSR_SEED;
        sinkLfsr = LFSR_SEED;
        prevByte = '0;
        stallActive = 1'b0;
        bytesSent = 0;
        wordsReceived = 0;
        cycles = 0;
        while (resetn !== 1'b1 && cycles < RESET_TIMEOUT)
        begin
            @(negedge aclk);
            cycles++;
        end
        assert (resetn === 1'b1) else failRun("timeout waiting for reset release");
        // Outputs still hold what the last reset edge loaded
        assert (!tvalid)
        else failRun($sformatf("error at %0d ns: o_tvalid is %b, expected 0", $time, tvalid));
        assert (cts)
        else failRun($sformatf("error at %0d ns: o_cts is %b, expected 1", $time, cts));
        assert (!miso)
        else failRun($sformatf("error at %0d ns: o_miso is %b, expected 0", $time, miso));
        @(posedge aclk);
        ncs <= 1'b0;
        repeat (SCK_HALF) @(posedge aclk);
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            if (STIM_TABLE[row].abortFirst)
            begin
                abortPartialByte();
            end
            expected.push_back(STIM_TABLE[row].expWord);
            for (int k = 0; k < LANES; k++)
            begin
                sendByte(wireByte(STIM_TABLE[row].sendOrder, k));
            end
            if (STIM_TABLE[row].stallAfter)
            begin
                stallPhase();
            end
        end
        cycles = 0;
        while (expected.size() > 0 && cycles < DRAIN_TIMEOUT)
        begin
            @(posedge aclk);
            cycles++;
        end
        // Any duplicate word would still reach the sink here
        repeat (4 * SCK_HALF) @(posedge aclk);
        if (expected.size() == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            failRun("timeout waiting for the stream to deliver every word");
        end
    end

endmodule

`default_nettype wire

// File: sim/tbClock.sv
// Testbench clock and reset
// 100 MHz aclk, resetn held low for the first 16 cycles

`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic aclk,
    output logic resetn
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial
    begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/serialPkg.sv
hdl/streamPkg.sv
hdl/spiRx.sv
hdl/byteFifo.sv
hdl/wordPacker.sv
hdl/bridgeCtrl.sv
hdl/serialToStream.sv
sim/tbClock.sv
sim/serialToStreamTb.sv
